// File: filelist.f
+incdir+testbench
logic/rv_decode_pkg.sv
logic/rv_i_decoder.sv
logic/rv_m_decoder.sv
logic/rv_decoder.sv
logic/rv_fetch_wb.sv
logic/rv_decode_stage.sv
testbench/tb_rv_decode_assertions.sv
testbench/tb_rv_decode_stage.sv

// File: logic/rv_decode_pkg.sv
package rv_decode_pkg;

  //////////////////////////////
  // basic widths
  //////////////////////////////

  typedef logic [31:0] instr_t;   // one rv32 instruction word
  typedef logic [31:0] addr_t;    // byte address of an instruction
  typedef logic [6:0]  opcode_t;  // major opcode field, instr[6:0]

  localparam addr_t RESET_PC = 32'h0000_0000;  // first fetch after reset

  // major opcodes, rv32 base
  localparam opcode_t OPCODE_LUI      = 7'b0110111;
  localparam opcode_t OPCODE_AUIPC    = 7'b0010111;
  localparam opcode_t OPCODE_JAL      = 7'b1101111;
  localparam opcode_t OPCODE_JALR     = 7'b1100111;
  localparam opcode_t OPCODE_BRANCH   = 7'b1100011;
  localparam opcode_t OPCODE_LOAD     = 7'b0000011;
  localparam opcode_t OPCODE_STORE    = 7'b0100011;
  localparam opcode_t OPCODE_OPIMM    = 7'b0010011;
  localparam opcode_t OPCODE_OP       = 7'b0110011;
  localparam opcode_t OPCODE_MISC_MEM = 7'b0001111;
  localparam opcode_t OPCODE_SYSTEM   = 7'b1110011;

  //////////////////////////////
  // control encodings
  //////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // branch compares
  } alu_op_e;

  // order follows funct3 of the M extension
  typedef enum logic [2:0] {
    MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU,
    MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU
  } mul_op_e;

  typedef enum logic [1:0] {
    BRANCH_NONE, BRANCH_JAL, BRANCH_JALR, BRANCH_COND
  } ctrl_transfer_e;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_sel_e;

  typedef enum logic [1:0] {
    DT_BYTE, DT_HALF, DT_WORD
  } data_type_e;

  // decoded control packet, 28 bits
  typedef struct packed {
    logic           match;          // sub-decoder recognised the word
    logic           illegal_insn;
    logic           alu_en;
    alu_op_e        alu_operator;
    imm_sel_e       imm_b_sel;      // immediate used as operand b
    logic           mult_en;
    mul_op_e        mult_operator;
    logic           rf_we;
    logic [1:0]     rf_re;          // bit 0 rs1, bit 1 rs2
    logic           data_req;
    logic           data_we;
    data_type_e     data_type;
    logic           data_sign_ext;  // loads only
    ctrl_transfer_e ctrl_transfer;
    logic           ecall_insn;
    logic           ebrk_insn;
    logic           fencei_insn;
  } decode_ctrl_t;

  // nothing enabled, nothing matched
  localparam decode_ctrl_t DECODER_CTRL_IDLE = '{
    match:         1'b0,
    illegal_insn:  1'b0,
    alu_en:        1'b0,
    alu_operator:  ALU_ADD,
    imm_b_sel:     IMM_NONE,
    mult_en:       1'b0,
    mult_operator: MUL_MUL,
    rf_we:         1'b0,
    rf_re:         2'b00,
    data_req:      1'b0,
    data_we:       1'b0,
    data_type:     DT_BYTE,
    data_sign_ext: 1'b0,
    ctrl_transfer: BRANCH_NONE,
    ecall_insn:    1'b0,
    ebrk_insn:     1'b0,
    fencei_insn:   1'b0
  };

  //////////////////////////////
  // instruction bus
  //////////////////////////////

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;   // always low, read only port
    addr_t adr;
  } wb_m2s_t;

  typedef struct packed {
    logic   ack;
    instr_t dat;
  } wb_s2m_t;

  typedef enum logic {
    FS_IDLE,  // waiting for room in IF/ID
    FS_BUS    // read in flight
  } fetch_state_e;

endpackage

// File: logic/rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage (
  input  logic                        clk,
  input  logic                        rst_i,
  output rv_decode_pkg::wb_m2s_t      wb_o,        // instruction memory
  input  rv_decode_pkg::wb_s2m_t      wb_i,
  input  logic                        id_ready_i,  // consumer side
  output logic                        id_valid_o,
  output rv_decode_pkg::addr_t        id_pc_o,
  output rv_decode_pkg::decode_ctrl_t id_ctrl_o
);
  import rv_decode_pkg::*;

  instr_t id_instr;    // IF/ID word into the decoder
  logic   hold_empty;  // IF/ID empty

  rv_fetch_wb fetch0 (
    .clk          (clk),
    .rst_i        (rst_i),
    .wb_o         (wb_o),
    .wb_i         (wb_i),
    .id_ready_i   (id_ready_i),
    .id_valid_o   (id_valid_o),
    .id_pc_o      (id_pc_o),
    .instr_o      (id_instr),
    .hold_empty_o (hold_empty)
  );

  rv_decoder decoder0 (
    .instr_i       (id_instr),
    .deassert_we_i (hold_empty),
    .ctrl_o        (id_ctrl_o)
  );

endmodule

// File: logic/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_decode_pkg::instr_t       instr_i,        // from IF/ID
  input  logic                        deassert_we_i,  // stage empty, kill side effects
  output rv_decode_pkg::decode_ctrl_t ctrl_o
);
  import rv_decode_pkg::*;

  decode_ctrl_t i_ctrl;    // base isa candidate
  decode_ctrl_t m_ctrl;    // mul/div candidate
  decode_ctrl_t ctrl_mux;  // selected before deassert

  rv_i_decoder i_decoder0 (
    .instr_i (instr_i),
    .ctrl_o  (i_ctrl)
  );

  rv_m_decoder m_decoder0 (
    .instr_i (instr_i),
    .ctrl_o  (m_ctrl)
  );

  // extension match wins, base covers the rest incl. illegal
  always_comb begin
    unique case (1'b1)
      m_ctrl.match: ctrl_mux = m_ctrl;
      default:      ctrl_mux = i_ctrl;
    endcase
  end

  // no valid instruction, so nothing may act on the packet
  always_comb begin
    ctrl_o = ctrl_mux;
    if (deassert_we_i) begin
      ctrl_o.alu_en        = 1'b0;
      ctrl_o.mult_en       = 1'b0;
      ctrl_o.rf_we         = 1'b0;
      ctrl_o.data_req      = 1'b0;
      ctrl_o.ctrl_transfer = BRANCH_NONE;
    end
  end

endmodule

// File: logic/rv_fetch_wb.sv
`timescale 1ns/1ps

module rv_fetch_wb (
  input  logic                   clk,
  input  logic                   rst_i,
  output rv_decode_pkg::wb_m2s_t wb_o,          // instruction bus request
  input  rv_decode_pkg::wb_s2m_t wb_i,          // instruction bus response
  input  logic                   id_ready_i,    // consumer takes the packet
  output logic                   id_valid_o,    // IF/ID holds an instruction
  output rv_decode_pkg::addr_t   id_pc_o,       // pc of the held instruction
  output rv_decode_pkg::instr_t  instr_o,       // held instruction word
  output logic                   hold_empty_o   // IF/ID empty, decoder deasserts
);
  import rv_decode_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  addr_t        pc_q;      // address of the next read
  addr_t        id_pc_q;   // address of the word in IF/ID
  instr_t       instr_q;
  logic         valid_q;
  logic         handshake;  // packet leaves this cycle
  logic         can_issue;  // IF/ID free by the next edge
  logic         bus_ack;

  assign handshake = valid_q & id_ready_i;
  assign can_issue = ~valid_q | id_ready_i;
  assign bus_ack   = (state_q == FS_BUS) & wb_i.ack;

  //////////////////////////////
  // fetch fsm
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      FS_IDLE: begin
        if (can_issue) begin
          state_d = FS_BUS;  // slot is free, start the read
        end
      end
      FS_BUS: begin
        if (wb_i.ack) begin
          state_d = FS_IDLE;  // word lands in IF/ID, drop cyc/stb
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= FS_IDLE;
      pc_q    <= RESET_PC;
      id_pc_q <= RESET_PC;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (bus_ack) begin
        pc_q    <= pc_q + 32'd4;  // sequential stream only
        id_pc_q <= pc_q;
        valid_q <= 1'b1;
      end else if (handshake) begin
        valid_q <= 1'b0;
      end
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (bus_ack) begin
      instr_q <= wb_i.dat;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign wb_o.cyc     = (state_q == FS_BUS);
  assign wb_o.stb     = (state_q == FS_BUS);  // single beat, same as cyc
  assign wb_o.we      = 1'b0;
  assign wb_o.adr     = pc_q;  // held until ack
  assign id_valid_o   = valid_q;
  assign id_pc_o      = id_pc_q;
  assign instr_o      = instr_q;
  assign hold_empty_o = ~valid_q;

endmodule

// File: logic/rv_i_decoder.sv
`timescale 1ns/1ps

module rv_i_decoder (
  input  rv_decode_pkg::instr_t       instr_i,
  output rv_decode_pkg::decode_ctrl_t ctrl_o   // base isa candidate
);
  import rv_decode_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;  // no rv32i encoding matched

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // shared by OP and OP-IMM, alt is funct7 bit 5
  function automatic alu_op_e alu_arith(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  //////////////////////////////
  // opcode decode
  //////////////////////////////

  always_comb begin
    ctrl_o  = DECODER_CTRL_IDLE;
    illegal = 1'b0;
    case (opcode)
      OPCODE_LUI, OPCODE_AUIPC: begin  // operand a is zero or pc
        ctrl_o.alu_en    = 1'b1;
        ctrl_o.imm_b_sel = IMM_U;
        ctrl_o.rf_we     = 1'b1;
      end
      OPCODE_JAL: begin
        ctrl_o.alu_en        = 1'b1;  // link address pc + 4
        ctrl_o.imm_b_sel     = IMM_J;
        ctrl_o.rf_we         = 1'b1;
        ctrl_o.ctrl_transfer = BRANCH_JAL;
      end
      OPCODE_JALR: begin
        illegal              = (funct3 != 3'b000);
        ctrl_o.alu_en        = 1'b1;
        ctrl_o.imm_b_sel     = IMM_I;
        ctrl_o.rf_we         = 1'b1;
        ctrl_o.rf_re         = 2'b01;
        ctrl_o.ctrl_transfer = BRANCH_JALR;
      end
      OPCODE_BRANCH: begin
        ctrl_o.alu_en        = 1'b1;
        ctrl_o.imm_b_sel     = IMM_B;
        ctrl_o.rf_re         = 2'b11;
        ctrl_o.ctrl_transfer = BRANCH_COND;
        case (funct3)
          3'b000:  ctrl_o.alu_operator = ALU_EQ;
          3'b001:  ctrl_o.alu_operator = ALU_NE;
          3'b100:  ctrl_o.alu_operator = ALU_LT;
          3'b101:  ctrl_o.alu_operator = ALU_GE;
          3'b110:  ctrl_o.alu_operator = ALU_LTU;
          3'b111:  ctrl_o.alu_operator = ALU_GEU;
          default: illegal = 1'b1;  // 010, 011 unused
        endcase
      end
      OPCODE_LOAD: begin
        illegal              = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
        ctrl_o.alu_en        = 1'b1;  // address add
        ctrl_o.imm_b_sel     = IMM_I;
        ctrl_o.rf_we         = 1'b1;
        ctrl_o.rf_re         = 2'b01;
        ctrl_o.data_req      = 1'b1;
        ctrl_o.data_type     = data_type_e'(funct3[1:0]);
        ctrl_o.data_sign_ext = ~funct3[2];  // lbu/lhu zero extend
      end
      OPCODE_STORE: begin
        illegal          = funct3[2] || (funct3[1:0] == 2'b11);
        ctrl_o.alu_en    = 1'b1;
        ctrl_o.imm_b_sel = IMM_S;
        ctrl_o.rf_re     = 2'b11;
        ctrl_o.data_req  = 1'b1;
        ctrl_o.data_we   = 1'b1;
        ctrl_o.data_type = data_type_e'(funct3[1:0]);
      end
      OPCODE_OPIMM: begin
        ctrl_o.alu_en       = 1'b1;
        ctrl_o.imm_b_sel    = IMM_I;
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.rf_re        = 2'b01;
        ctrl_o.alu_operator = alu_arith(funct3, funct7[5] & (funct3 == 3'b101));
        // shifts take shamt, upper bits fixed
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      OPCODE_OP: begin
        ctrl_o.alu_en       = 1'b1;
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.rf_re        = 2'b11;
        ctrl_o.alu_operator = alu_arith(funct3, funct7[5]);
        if (funct7 == 7'h20) begin
          illegal = (funct3 != 3'b000) && (funct3 != 3'b101);  // only sub and sra
        end else if (funct7 != 7'h00) begin
          illegal = 1'b1;
        end
      end
      OPCODE_MISC_MEM: begin
        case (funct3)
          3'b000:  ;  // fence, nothing to do in order
          3'b001:  ctrl_o.fencei_insn = 1'b1;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_SYSTEM: begin
        if (instr_i[31:7] == 25'h0) begin
          ctrl_o.ecall_insn = 1'b1;
        end else if (instr_i[31:7] == {12'h001, 13'h0}) begin
          ctrl_o.ebrk_insn = 1'b1;
        end else begin
          illegal = 1'b1;  // no csr or privileged ops here
        end
      end
      default: illegal = 1'b1;
    endcase

    // unrecognised words carry only the flag
    if (illegal) begin
      ctrl_o              = DECODER_CTRL_IDLE;
      ctrl_o.illegal_insn = 1'b1;
    end else begin
      ctrl_o.match = 1'b1;
    end
  end

endmodule

// File: logic/rv_m_decoder.sv
`timescale 1ns/1ps

module rv_m_decoder (
  input  rv_decode_pkg::instr_t       instr_i,
  output rv_decode_pkg::decode_ctrl_t ctrl_o   // mul/div candidate
);
  import rv_decode_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_muldiv;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign is_muldiv = (opcode == OPCODE_OP) && (funct7 == 7'h01);

  always_comb begin
    ctrl_o = DECODER_CTRL_IDLE;  // no match, base decoder decides
    if (is_muldiv) begin
      ctrl_o.match         = 1'b1;
      ctrl_o.mult_en       = 1'b1;
      ctrl_o.rf_we         = 1'b1;
      ctrl_o.rf_re         = 2'b11;
      ctrl_o.mult_operator = mul_op_e'(funct3);  // enum follows funct3 order
    end
  end

endmodule

// File: testbench/tb_rv_decode_assertions.sv
`timescale 1ns/1ps

module tb_rv_decode_assertions (
  input logic                        clk,
  input logic                        rst_i,
  input rv_decode_pkg::wb_m2s_t      wb_o,
  input rv_decode_pkg::wb_s2m_t      wb_i,
  input logic                        id_ready_i,
  input logic                        id_valid_o,
  input rv_decode_pkg::addr_t        id_pc_o,
  input rv_decode_pkg::decode_ctrl_t id_ctrl_o
);

  int fail_cnt = 0;  // failed assertions so far

  // wishbone classic, stb only inside a read cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
    wb_o.stb |-> wb_o.cyc && !wb_o.we)
    else begin
      fail_cnt++;
      $error("stb high without cyc or with we set");
    end

  // address held while the slave inserts wait states
  adr_held: assert property (@(posedge clk) disable iff (rst_i)
    wb_o.stb && !wb_i.ack |=> $stable(wb_o.adr))
    else begin
      fail_cnt++;
      $error("adr changed before ack");
    end

  // stalled packet stays put
  out_held: assert property (@(posedge clk) disable iff (rst_i)
    id_valid_o && !id_ready_i |=> id_valid_o && $stable(id_pc_o) && $stable(id_ctrl_o))
    else begin
      fail_cnt++;
      $error("packet changed while stalled");
    end

endmodule

bind rv_decode_stage tb_rv_decode_assertions asrt0 (
  .clk        (clk),
  .rst_i      (rst_i),
  .wb_o       (wb_o),
  .wb_i       (wb_i),
  .id_ready_i (id_ready_i),
  .id_valid_o (id_valid_o),
  .id_pc_o    (id_pc_o),
  .id_ctrl_o  (id_ctrl_o)
);

// File: testbench/tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

//////////////////////////////
// reference decode
//////////////////////////////

// common shape of every alu user
function automatic decode_ctrl_t base_packet(input imm_sel_e imm, input logic we,
                                             input logic [1:0] re);
  decode_ctrl_t c;
  c           = DECODER_CTRL_IDLE;
  c.match     = 1'b1;
  c.alu_en    = 1'b1;
  c.imm_b_sel = imm;
  c.rf_we     = we;
  c.rf_re     = re;  // bit 0 rs1, bit 1 rs2
  return c;
endfunction

// funct3 table of OP and OP-IMM, alt selects sub/sra
function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return alt ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

function automatic decode_ctrl_t expected_ctrl(input instr_t w);
  decode_ctrl_t c;
  logic [2:0]   f3;
  logic [6:0]   f7;
  logic         bad;  // word not in rv32im
  f3      = w[14:12];
  f7      = w[31:25];
  bad     = 1'b0;
  c       = DECODER_CTRL_IDLE;
  c.match = 1'b1;
  if (w[6:0] == OPCODE_OP && f7 == 7'h01) begin
    // mul/div wins over the base decode
    c.mult_en       = 1'b1;
    c.mult_operator = mul_op_e'(f3);  // funct3 order of the M extension
    c.rf_we         = 1'b1;
    c.rf_re         = 2'b11;
    return c;
  end
  case (w[6:0])
    OPCODE_LUI, OPCODE_AUIPC: c = base_packet(IMM_U, 1'b1, 2'b00);
    OPCODE_JAL: begin
      c               = base_packet(IMM_J, 1'b1, 2'b00);
      c.ctrl_transfer = BRANCH_JAL;
    end
    OPCODE_JALR: begin
      c               = base_packet(IMM_I, 1'b1, 2'b01);
      c.ctrl_transfer = BRANCH_JALR;
      bad             = (f3 != 3'd0);
    end
    OPCODE_BRANCH: begin
      c               = base_packet(IMM_B, 1'b0, 2'b11);
      c.ctrl_transfer = BRANCH_COND;
      case (f3)
        3'd0:    c.alu_operator = ALU_EQ;
        3'd1:    c.alu_operator = ALU_NE;
        3'd4:    c.alu_operator = ALU_LT;
        3'd5:    c.alu_operator = ALU_GE;
        3'd6:    c.alu_operator = ALU_LTU;
        3'd7:    c.alu_operator = ALU_GEU;
        default: bad = 1'b1;
      endcase
    end
    OPCODE_LOAD: begin
      c               = base_packet(IMM_I, 1'b1, 2'b01);
      c.data_req      = 1'b1;
      c.data_type     = data_type_e'(f3[1:0]);
      c.data_sign_ext = ~f3[2];  // lb lh lw sign extend
      bad             = (f3 == 3'd3) || (f3 >= 3'd6);
    end
    OPCODE_STORE: begin
      c           = base_packet(IMM_S, 1'b0, 2'b11);
      c.data_req  = 1'b1;
      c.data_we   = 1'b1;
      c.data_type = data_type_e'(f3[1:0]);
      bad         = (f3 >= 3'd3);
    end
    OPCODE_OPIMM: begin
      c              = base_packet(IMM_I, 1'b1, 2'b01);
      c.alu_operator = arith_op(f3, (f3 == 3'd5) && (f7 == 7'h20));
      bad            = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                       ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
    end
    OPCODE_OP: begin
      c              = base_packet(IMM_NONE, 1'b1, 2'b11);
      c.alu_operator = arith_op(f3, f7 == 7'h20);
      bad            = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5)));
    end
    OPCODE_MISC_MEM: begin
      c.fencei_insn = (f3 == 3'd1);  // plain fence has no side effect
      bad           = (f3 > 3'd1);
    end
    OPCODE_SYSTEM: begin
      c.ecall_insn = (w[31:7] == 25'h0000000);
      c.ebrk_insn  = (w[31:7] == 25'h0002000);  // imm 1
      bad          = !(c.ecall_insn || c.ebrk_insn);
    end
    default: bad = 1'b1;
  endcase
  if (bad) begin
    c              = DECODER_CTRL_IDLE;
    c.illegal_insn = 1'b1;
  end
  return c;
endfunction

//////////////////////////////
// stimulus words
//////////////////////////////

// about 85 percent legal rv32im, the rest raw random
function automatic instr_t random_instr();
  logic [31:0] r;
  logic [2:0]  f3;
  logic [6:0]  f7;
  instr_t      w;
  r  = $urandom;
  f3 = r[14:12];
  f7 = 7'h00;
  if ($urandom % 100 >= 85) begin
    w = $urandom;
  end else begin
    case ($urandom % 12)
      0: w = {r[31:7], OPCODE_LUI};
      1: w = {r[31:7], OPCODE_AUIPC};
      2: w = {r[31:7], OPCODE_JAL};
      3: w = {r[31:15], 3'd0, r[11:7], OPCODE_JALR};
      4: begin
        if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;  // skip unused compares
        w = {r[31:15], f3, r[11:7], OPCODE_BRANCH};
      end
      5: begin
        if (f3 == 3'd3 || f3 >= 3'd6) f3 = 3'd2;
        w = {r[31:15], f3, r[11:7], OPCODE_LOAD};
      end
      6: begin
        f3 = (r[13:12] == 2'b11) ? 3'd2 : {1'b0, r[13:12]};
        w  = {r[31:15], f3, r[11:7], OPCODE_STORE};
      end
      7: begin
        if (f3 == 3'd1) f7 = 7'h00;  // slli
        else if (f3 == 3'd5) f7 = r[30] ? 7'h20 : 7'h00;
        else f7 = r[31:25];          // immediate bits, free
        w = {f7, r[24:15], f3, r[11:7], OPCODE_OPIMM};
      end
      8: begin
        f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        w  = {f7, r[24:15], f3, r[11:7], OPCODE_OP};
      end
      9:  w = {r[31:15], 2'b00, r[12], r[11:7], OPCODE_MISC_MEM};
      10: w = r[0] ? 32'h0000_0073 : 32'h0010_0073;  // ecall or ebreak
      default: w = {7'h01, r[24:15], f3, r[11:7], OPCODE_OP};  // mul/div
    endcase
  end
  return w;
endfunction

`endif

// File: testbench/tb_rv_decode_stage.sv
`timescale 1ns/1ps

module tb_rv_decode_stage;
  import rv_decode_pkg::*;

  `include "tb_decode_model.svh"

  localparam int NUM_INSTR      = 300;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 12;  // worst wait plus stalls

  logic         clk        = 1'b0;
  logic         rst_i      = 1'b1;
  wb_s2m_t      wb_i       = '0;
  logic         id_ready_i = 1'b0;
  wb_m2s_t      wb_o;
  logic         id_valid_o;
  addr_t        id_pc_o;
  decode_ctrl_t id_ctrl_o;

  instr_t mem [NUM_INSTR];  // instruction image, word per index
  int     wait_cnt;         // wait states left for this read
  int     accepted    = 0;
  int     cycle_cnt   = 0;
  int     ctrl_errors = 0;
  int     pc_errors   = 0;
  int     bus_errors  = 0;
  addr_t  exp_pc;           // next pc the consumer should see

  rv_decode_stage dut0 (
    .clk        (clk),
    .rst_i      (rst_i),
    .wb_o       (wb_o),
    .wb_i       (wb_i),
    .id_ready_i (id_ready_i),
    .id_valid_o (id_valid_o),
    .id_pc_o    (id_pc_o),
    .id_ctrl_o  (id_ctrl_o)
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic check_ctrl(input string name, input decode_ctrl_t exp, input decode_ctrl_t act);
    if (act !== exp) begin
      ctrl_errors++;
      $display("Error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_pc(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      pc_errors++;
      $display("Error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  // past the image the fetch only prefetches, serve nops
  function automatic instr_t fetch_word(input addr_t a);
    if ((a >> 2) < NUM_INSTR) return mem[a >> 2];
    return 32'h0000_0013;
  endfunction

  // only the fields that must be quiet without a valid word
  function automatic decode_ctrl_t enable_view(input decode_ctrl_t c);
    decode_ctrl_t v;
    v               = DECODER_CTRL_IDLE;
    v.alu_en        = c.alu_en;
    v.mult_en       = c.mult_en;
    v.rf_we         = c.rf_we;
    v.data_req      = c.data_req;
    v.ctrl_transfer = c.ctrl_transfer;
    return v;
  endfunction

  //////////////////////////////
  // bus slave and consumer
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_i || wb_i.ack) begin
      wb_i.ack <= 1'b0;          // single beat, then new wait count
      wait_cnt <= $urandom % 4;
    end else if (wb_o.cyc && wb_o.stb) begin
      if (wait_cnt == 0) begin
        wb_i.ack <= 1'b1;
        wb_i.dat <= fetch_word(wb_o.adr);
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_i) id_ready_i <= 1'b0;
    else id_ready_i <= ($urandom % 100) < 60;  // about 60 percent ready
  end

  //////////////////////////////
  // checks, mid cycle
  //////////////////////////////

  always @(negedge clk) begin : check_outputs
    decode_ctrl_t exp_ctrl;
    string        kind;
    if (!id_valid_o) begin
      check_ctrl("idle enables", DECODER_CTRL_IDLE, enable_view(id_ctrl_o));
    end
    if (id_valid_o && !id_ready_i && wb_o.cyc) begin
      bus_errors++;
      $display("bus request started while a packet waits in IF/ID");
    end
    if (id_valid_o && id_ready_i) begin
      exp_ctrl = expected_ctrl(fetch_word(exp_pc));  // word served at the expected pc
      if (exp_ctrl.mult_en) kind = "muldiv word";
      else if (exp_ctrl.illegal_insn) kind = "illegal word";
      else kind = "base word";
      check_pc("packet pc", exp_pc, id_pc_o);
      check_ctrl(kind, exp_ctrl, id_ctrl_o);
      exp_pc = exp_pc + 32'd4;  // strictly sequential stream
      accepted++;
    end
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt == TIMEOUT_CYCLES);
    $display("run stalled: %0d of %0d packets accepted after %0d cycles",
             accepted, NUM_INSTR, cycle_cnt);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int total;
    void'($urandom(73));
    for (int i = 0; i < NUM_INSTR; i++) begin
      mem[i] = random_instr();
    end
    exp_pc = RESET_PC;
    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    wait (accepted == NUM_INSTR);
    repeat (4) @(posedge clk);  // let the last assertions settle
    total = ctrl_errors + pc_errors + bus_errors + dut0.asrt0.fail_cnt;
    $display("errors: decode %0d, pc %0d, bus %0d, assertion %0d",
             ctrl_errors, pc_errors, bus_errors, dut0.asrt0.fail_cnt);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
